// ==== hw/sram_pkg.sv ====
package sram_pkg;

  // channel widths
  localparam int axi_addr_bits = 32;
  localparam int axi_data_bits = 32;
  localparam int axi_strb_bits = axi_data_bits / 8;  // one per byte lane

  // ram geometry
  localparam int sram_idx_bits = 8;
  localparam int sram_idx_lsb = 2;                    // byte address to word index
  localparam int sram_depth_words = 256;
  localparam int sram_read_cycles = 1;                // rd_en to rd_data_valid, 1..4

  typedef logic [axi_addr_bits-1:0] axi_addr_t;
  typedef logic [axi_data_bits-1:0] axi_data_t;
  typedef logic [axi_strb_bits-1:0] axi_strb_t;
  typedef logic [sram_idx_bits-1:0] sram_idx_t;

  // complete write request, 44 bits
  typedef struct packed {
    sram_idx_t idx;
    axi_data_t data;
    axi_strb_t strb;
  } wr_req_t;

  typedef enum logic [2:0] {
    idle,
    write,
    read_issue,
    read_wait,
    resp_hold
  } ctrl_state_e;

endpackage

// ==== hw/sram_ctrl.sv ====
module sram_ctrl import sram_pkg::*; (
  input  logic        aclk,
  input  logic        areset,
  input  logic        arvalid,
  input  axi_addr_t   araddr,
  output logic        arready,
  input  logic        wr_pending,
  output logic        wr_commit,
  output logic        rd_en,
  output sram_idx_t   rd_idx,
  input  logic        rd_data_valid,
  input  logic        resp_busy
);

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic        ar_open;  // registered idle, low through reset
  logic        ar_hs;

  // writes win over reads in idle
  assign arready   = ar_open && !wr_pending;
  assign ar_hs     = arvalid && arready;
  assign wr_commit = (state == write);
  assign rd_en     = (state == read_issue);

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (wr_pending) begin
          state_next = write;
        end else if (ar_hs) begin
          state_next = read_issue;
        end
      end
      write: begin
        state_next = idle;  // single commit cycle
      end
      read_issue: begin
        state_next = read_wait;
      end
      read_wait: begin
        if (rd_data_valid) begin
          state_next = resp_hold;
        end
      end
      resp_hold: begin
        // wait for the r transfer to drain
        if (!resp_busy) begin
          state_next = idle;
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      state   <= idle;
      ar_open <= 1'b0;
    end else begin
      state   <= state_next;
      ar_open <= (state_next == idle);
    end
  end

  // read index, word bits only
  always_ff @(posedge aclk) begin
    if (ar_hs) begin
      rd_idx <= araddr[sram_idx_lsb +: sram_idx_bits];
    end
  end

endmodule

// ==== hw/wr_capture.sv ====
module wr_capture import sram_pkg::*; (
  input  logic        aclk,
  input  logic        areset,
  input  logic        awvalid,
  input  axi_addr_t   awaddr,
  output logic        awready,
  input  logic        wvalid,
  input  axi_data_t   wdata,
  input  axi_strb_t   wstrb,
  output logic        wready,
  output logic        wr_pending,
  output wr_req_t     wr_req,
  input  logic        wr_commit
);

  logic      aw_full;
  logic      w_full;
  logic      aw_full_next;
  logic      w_full_next;
  logic      aw_hs;
  logic      w_hs;
  sram_idx_t aw_idx;
  axi_data_t w_data;
  axi_strb_t w_strb;

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;

  // commit empties both, a transfer fills one
  assign aw_full_next = wr_commit ? 1'b0 : (aw_full || aw_hs);
  assign w_full_next  = wr_commit ? 1'b0 : (w_full || w_hs);

  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
    end else begin
      aw_full <= aw_full_next;
      w_full  <= w_full_next;
      awready <= !aw_full_next;  // ready while empty
      wready  <= !w_full_next;
    end
  end

  always_ff @(posedge aclk) begin
    if (aw_hs) begin
      aw_idx <= awaddr[sram_idx_lsb +: sram_idx_bits];  // upper bits alias
    end
    if (w_hs) begin
      w_data <= wdata;
      w_strb <= wstrb;
    end
  end

  assign wr_pending = aw_full && w_full;

  always_comb begin
    wr_req.idx  = aw_idx;
    wr_req.data = w_data;
    wr_req.strb = w_strb;
  end

endmodule

// ==== hw/sram_array.sv ====
module sram_array import sram_pkg::*; (
  input  logic        aclk,
  input  logic        areset,
  input  logic        we,
  input  wr_req_t     wr_req,
  input  logic        rd_en,
  input  sram_idx_t   rd_idx,
  output axi_data_t   rd_data,
  output logic        rd_data_valid
);

  axi_data_t mem [sram_depth_words];

  // read delay line, stage 0 is the ram output register
  axi_data_t                   rd_pipe [sram_read_cycles];
  logic [sram_read_cycles-1:0] vld_pipe;

  // byte-lane write
  always_ff @(posedge aclk) begin
    if (we) begin
      for (int b = 0; b < axi_strb_bits; b++) begin
        if (wr_req.strb[b]) begin
          mem[wr_req.idx][8*b +: 8] <= wr_req.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_pipe[0] <= mem[rd_idx];
    end
    for (int i = 1; i < sram_read_cycles; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= rd_en;
      for (int i = 1; i < sram_read_cycles; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  assign rd_data       = rd_pipe[sram_read_cycles-1];
  assign rd_data_valid = vld_pipe[sram_read_cycles-1];

endmodule

// ==== hw/rd_resp_buf.sv ====
module rd_resp_buf import sram_pkg::*; (
  input  logic        aclk,
  input  logic        areset,
  input  logic        rd_data_valid,
  input  axi_data_t   rd_data,
  input  logic        rready,
  output logic        rvalid,
  output axi_data_t   data,
  output logic        resp_busy
);

  logic r_hs;

  assign r_hs = rvalid && rready;

  // one read in flight, so a new word never lands on a held one
  always_ff @(posedge aclk) begin
    if (areset) begin
      rvalid <= 1'b0;
    end else if (rd_data_valid) begin
      rvalid <= 1'b1;
    end else if (r_hs) begin
      rvalid <= 1'b0;
    end
  end

  // held stable under back-pressure
  always_ff @(posedge aclk) begin
    if (rd_data_valid) begin
      data <= rd_data;
    end
  end

  assign resp_busy = rvalid;  // controller waits on this

endmodule

// ==== hw/axi_sram_top.sv ====
module axi_sram_top import sram_pkg::*; (
  input  logic        aclk,
  input  logic        areset,
  input  axi_addr_t   araddr,
  input  logic        arvalid,
  output logic        arready,
  output axi_data_t   data,
  output logic        rvalid,
  input  logic        rready,
  input  axi_addr_t   awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  axi_data_t   wdata,
  input  axi_strb_t   wstrb,
  input  logic        wvalid,
  output logic        wready
);

  logic      wr_pending;
  logic      wr_commit;
  wr_req_t   wr_req;
  logic      rd_en;
  sram_idx_t rd_idx;
  axi_data_t rd_data;
  logic      rd_data_valid;
  logic      resp_busy;

  sram_ctrl u_ctrl (
    .aclk          (aclk),
    .areset        (areset),
    .arvalid       (arvalid),
    .araddr        (araddr),
    .arready       (arready),
    .wr_pending    (wr_pending),
    .wr_commit     (wr_commit),
    .rd_en         (rd_en),
    .rd_idx        (rd_idx),
    .rd_data_valid (rd_data_valid),
    .resp_busy     (resp_busy)
  );

  wr_capture u_wr_capture (
    .aclk       (aclk),
    .areset     (areset),
    .awvalid    (awvalid),
    .awaddr     (awaddr),
    .awready    (awready),
    .wvalid     (wvalid),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wready     (wready),
    .wr_pending (wr_pending),
    .wr_req     (wr_req),
    .wr_commit  (wr_commit)
  );

  sram_array u_array (
    .aclk          (aclk),
    .areset        (areset),
    .we            (wr_commit),  // commit is the write strobe
    .wr_req        (wr_req),
    .rd_en         (rd_en),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
  );

  rd_resp_buf u_rd_resp_buf (
    .aclk          (aclk),
    .areset        (areset),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data),
    .rready        (rready),
    .rvalid        (rvalid),
    .data          (data),
    .resp_busy     (resp_busy)
  );

endmodule

// ==== tests/clk_gen.sv ====
module clk_gen #(
  parameter int half_period = 4  // 8 ns period
) (
  output logic aclk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    aclk = 1'b0;
    forever begin
      #(half_period) aclk = ~aclk;
    end
  end

endmodule

// ==== tests/axi_sram_tb.sv ====
module axi_sram_tb import sram_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_patterns = 64;
  localparam int cycles_per_pattern = 200;

  // one line of the pattern file
  typedef struct packed {
    logic [3:0]  op;       // 0 write, 1 read
    axi_addr_t   addr;
    axi_data_t   data;
    axi_strb_t   strb;
    logic [3:0]  order;    // 0 together, 1 aw first, 2 w first
    logic [7:0]  max_hold; // rready hold bound
    axi_data_t   exp_word;
  } pattern_t;

  logic      aclk;
  logic      areset;
  axi_addr_t araddr;
  logic      arvalid;
  logic      arready;
  axi_data_t data;
  logic      rvalid;
  logic      rready;
  axi_addr_t awaddr;
  logic      awvalid;
  logic      awready;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic      wvalid;
  logic      wready;

  logic [$bits(pattern_t)-1:0] pattern_mem [max_patterns];
  axi_data_t                   shadow [sram_depth_words];
  int                          n_patterns = 0;
  bit                          patterns_loaded = 1'b0;

  clk_gen u_clk (.aclk(aclk));

  axi_sram_top uut (
    .aclk    (aclk),
    .areset  (areset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .data    (data),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic fail_value(input string msg);
    abort_run($sformatf("FAILED at %0d ns: %s", $time, msg));
  endtask

  // byte lanes with a set strobe take the new byte
  function automatic axi_data_t merge_bytes(input axi_data_t old_word,
                                            input axi_data_t new_word,
                                            input axi_strb_t strb);
    axi_data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic do_write(input axi_addr_t addr, input axi_data_t wd,
                          input axi_strb_t ws, input logic [3:0] order);
    bit aw_done;
    bit w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    while (!(aw_done && w_done)) begin
      @(posedge aclk);
      awaddr  <= addr;
      wdata   <= wd;
      wstrb   <= ws;
      awvalid <= !aw_done && (order != 4'd2 || w_done);
      wvalid  <= !w_done && (order != 4'd1 || aw_done);
      @(negedge aclk);
      if (aw_done && !w_done) begin
        assert (!awready) else fail_value("awready high while the address is held");
      end
      if (w_done && !aw_done) begin
        assert (!wready) else fail_value("wready high while the data is held");
      end
      if (awvalid && awready) begin
        aw_done = 1'b1;  // transfer on the coming edge
      end
      if (wvalid && wready) begin
        w_done = 1'b1;
      end
    end
    @(posedge aclk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
  endtask

  task automatic do_read(input axi_addr_t addr, input axi_data_t exp_word,
                         input logic [7:0] max_hold);
    int        lat;
    int        hold;
    axi_data_t held;
    @(posedge aclk);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge aclk);
    while (!arready) begin
      @(negedge aclk);
    end
    @(posedge aclk);  // ar transfer
    arvalid <= 1'b0;
    lat = 0;
    @(negedge aclk);
    while (!rvalid) begin
      assert (!arready) else fail_value("arready high while a read is in flight");
      lat++;
      @(negedge aclk);
    end
    assert (lat == 1 + sram_read_cycles) else
      fail_value($sformatf("rvalid after %0d cycles, expected %0d", lat, 1 + sram_read_cycles));
    assert (data == exp_word) else
      fail_value($sformatf("read 0x%08h gave 0x%08h, expected 0x%08h", addr, data, exp_word));
    held = data;
    hold = int'($urandom % (32'(max_hold) + 32'd1));
    repeat (hold) begin
      @(posedge aclk);
      @(negedge aclk);
      assert (rvalid && data == held) else fail_value("rvalid or data moved under back-pressure");
      assert (!arready) else fail_value("second read accepted while rvalid is held");
    end
    @(posedge aclk);
    rready <= 1'b1;
    @(negedge aclk);
    assert (rvalid && data == held) else fail_value("rvalid or data moved before the transfer");
    @(posedge aclk);  // r transfer
    rready <= 1'b0;
    @(negedge aclk);
    assert (!rvalid) else fail_value("rvalid still high after the r transfer");
    assert (!arready) else fail_value("arready high in the r transfer cycle");
  endtask

  initial begin
    pattern_t pat;
    areset  <= 1'b1;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    void'($urandom(32'hf55e));
    for (int i = 0; i < sram_depth_words; i++) begin
      shadow[i] = '0;
    end
    for (int i = 0; i < max_patterns; i++) begin
      pattern_mem[i] = '1;  // all ones marks the end
    end
    $readmemh("tests/sram_patterns.txt", pattern_mem);
    for (int i = 0; i < max_patterns; i++) begin
      pat = pattern_mem[i];
      if (pat.op == 4'hf) begin
        break;
      end
      n_patterns++;
    end
    if (n_patterns == 0) begin
      abort_run("pattern file tests/sram_patterns.txt is missing or empty");
    end
    patterns_loaded = 1'b1;

    @(posedge aclk);
    @(negedge aclk);
    assert (!arready && !awready && !wready && !rvalid) else
      fail_value("ready or rvalid high during reset");
    @(posedge aclk);
    areset <= 1'b0;
    @(negedge aclk);
    assert (!arready && !awready && !wready && !rvalid) else
      fail_value("ready or rvalid high right after reset");
    @(posedge aclk);
    @(negedge aclk);
    assert (arready && awready && wready && !rvalid) else
      fail_value("readys did not rise on the first edge after reset");

    for (int i = 0; i < n_patterns; i++) begin
      pat = pattern_mem[i];
      case (pat.op)
        4'h0: begin
          do_write(pat.addr, pat.data, pat.strb, pat.order);
          shadow[pat.addr[9:2]] = merge_bytes(shadow[pat.addr[9:2]], pat.data, pat.strb);
        end
        4'h1: begin
          assert (shadow[pat.addr[9:2]] == pat.exp_word) else
            fail_value($sformatf("pattern %0d expects 0x%08h, model holds 0x%08h",
                                 i, pat.exp_word, shadow[pat.addr[9:2]]));
          do_read(pat.addr, pat.exp_word, pat.max_hold);
        end
        default: begin
          abort_run($sformatf("pattern %0d has an unknown operation code", i));
        end
      endcase
    end

    $display("All tests passed!");
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (patterns_loaded);
    limit = n_patterns * cycles_per_pattern;
    repeat (limit) begin
      @(posedge aclk);
    end
    abort_run($sformatf("timeout, the run did not finish within %0d clock cycles", limit));
  end

endmodule

// ==== tests/sram_patterns.txt ====
// op addr data strb order rready_max expect, all hex, fields split by _
// op 0 write 1 read; order 0 aw and w together, 1 aw first, 2 w first
// full-strobe writes in each ordering, read back
0_00000000_11223344_f_0_00_00000000
1_00000000_00000000_0_0_00_11223344
0_00000004_a5a5a5a5_f_1_00_00000000
1_00000004_00000000_0_0_00_a5a5a5a5
0_00000008_0badf00d_f_2_00_00000000
1_00000008_00000000_0_0_00_0badf00d
// partial strobes over word 0
0_00000000_deadbeef_1_0_00_00000000
1_00000000_00000000_0_0_00_112233ef
0_00000000_cafebabe_6_1_00_00000000
1_00000000_00000000_0_0_00_11febaef
0_00000000_77000000_8_2_00_00000000
1_00000000_00000000_0_0_00_77febaef
0_00000000_ffffffff_0_1_00_00000000
1_00000000_00000000_0_0_00_77febaef
// partial strobes over word 1
0_00000004_12345678_3_0_00_00000000
1_00000004_00000000_0_0_00_a5a55678
0_00000004_9abcdef0_c_2_00_00000000
1_00000004_00000000_0_0_00_9abc5678
// back-to-back writes to one word
0_00000010_00000001_f_2_00_00000000
0_00000010_00000200_2_1_00_00000000
0_00000010_00030000_4_0_00_00000000
1_00000010_00000000_0_0_18_00030201
// rready held low for a random count up to rready_max
1_00000000_00000000_0_0_0f_77febaef
1_00000004_00000000_0_0_20_9abc5678
1_00000008_00000000_0_0_08_0badf00d
// upper address bits alias the same word
0_00000408_13579bdf_f_1_00_00000000
1_00000008_00000000_0_0_04_13579bdf
0_fffffc0c_2468ace0_f_2_00_00000000
1_0000000c_00000000_0_0_00_2468ace0
1_8000000e_00000000_0_0_10_2468ace0
0_000003fc_55aa55aa_f_0_00_00000000
1_000007fc_00000000_0_0_00_55aa55aa
0_40000000_0f1e2d3c_f_1_00_00000000
1_00000000_00000000_0_0_06_0f1e2d3c
0_800007fd_00c300c3_5_0_00_00000000
1_000003fc_00000000_0_0_03_55c355c3

// ==== src.f ====
hw/sram_pkg.sv
hw/sram_ctrl.sv
hw/wr_capture.sv
hw/sram_array.sv
hw/rd_resp_buf.sv
hw/axi_sram_top.sv
tests/clk_gen.sv
tests/axi_sram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the SRAM slave testbench with Verilator
set -e

cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert \
  -f src.f \
  --top-module axi_sram_tb \
  --Mdir obj_dir \
  -o axi_sram_sim

./obj_dir/axi_sram_sim 2>&1 | tee "$log"

if grep -q "Test failures found" "$log"; then
  echo "simulation failed, see $log"
  exit 1
fi

echo "simulation passed"
